//--- vga_pkg.sv
package vga_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 640x480 timing, counted in pixel periods
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int h_total      = 800;      // Pixel periods per line
    localparam int v_total      = 521;      // Lines per frame
    localparam int h_sync_end   = 95;       // Last period with HS low
    localparam int v_sync_end   = 1;        // Last line with VS low
    localparam int h_offset     = 144;      // First visible period
    localparam int v_offset     = 31;       // First visible line
    localparam int h_visible    = 640;
    localparam int v_visible    = 480;

    localparam int cnt_w        = 10;       // Counter and coordinate width

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pattern geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int stripe_width  = 80;      // Eight stripes across 640
    localparam int checker_shift = 5;       // 32 pixel squares

    typedef enum logic [1:0] {
        pat_stripes = 2'd0,
        pat_solid   = 2'd1,
        pat_checker = 2'd2
    } pattern_e;                            // Code 3 is reserved

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int axi_addr_w = 4;
    localparam int axi_data_w = 32;

    localparam logic [axi_addr_w-1:0] reg_ctrl   = 4'h0;   // [0] enable, [2:1] pattern
    localparam logic [axi_addr_w-1:0] reg_color  = 4'h4;   // [2:0] solid colour
    localparam logic [axi_addr_w-1:0] reg_frames = 4'h8;   // Read only frame count
    localparam logic [axi_addr_w-1:0] reg_status = 4'hC;   // [0] config pending

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- vga_timing.sv
`timescale 1ns/1ps

module vga_timing import vga_pkg::*; (
    input  logic             clk_50M,
    input  logic             rst,
    output logic             pix_en,
    output logic             pix_clk,
    output logic             hs_raw,
    output logic             vs_raw,
    output logic             visible,
    output logic [cnt_w-1:0] row,
    output logic [cnt_w-1:0] col,
    output logic             frame_done
);

    logic [cnt_w-1:0] h_cnt;
    logic [cnt_w-1:0] v_cnt;
    logic             h_wrap;
    logic             v_wrap;
    logic             h_active;
    logic             v_active;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel rate from the 50 MHz clock
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_50M, posedge rst) begin
        if (rst) begin
            pix_clk <= 1'b0;
        end else begin
            pix_clk <= ~pix_clk;                // 25 MHz out to the DAC
        end
    end

    assign pix_en = ~pix_clk;                   // First cycle after reset is a pixel

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line and frame counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign h_wrap = (h_cnt == cnt_w'(h_total - 1));
    assign v_wrap = (v_cnt == cnt_w'(v_total - 1));

    always_ff @(posedge clk_50M, posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
        end else if (pix_en) begin
            if (h_wrap) begin
                h_cnt <= '0;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_50M, posedge rst) begin
        if (rst) begin
            v_cnt <= '0;
        end else if (pix_en && h_wrap) begin
            if (v_wrap) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    assign frame_done = pix_en && h_wrap && v_wrap;     // One clk_50M cycle per frame

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sync, visible window and coordinates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hs_raw = ~(h_cnt <= cnt_w'(h_sync_end));     // Active low
    assign vs_raw = ~(v_cnt <= cnt_w'(v_sync_end));

    assign h_active = (h_cnt >= cnt_w'(h_offset))
                   && (h_cnt < cnt_w'(h_offset + h_visible));
    assign v_active = (v_cnt >= cnt_w'(v_offset))
                   && (v_cnt < cnt_w'(v_offset + v_visible));

    assign visible = h_active && v_active;

    // Only meaningful while visible is high
    assign col = h_cnt - cnt_w'(h_offset);
    assign row = v_cnt - cnt_w'(v_offset);

endmodule

//--- vga_regs.sv
`timescale 1ns/1ps

module vga_regs import vga_pkg::*; (
    input  logic                  clk_50M,
    input  logic                  rst,

    input  logic [axi_addr_w-1:0] s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  logic [axi_data_w-1:0] s_wdata,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [1:0]            s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,

    input  logic [axi_addr_w-1:0] s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [axi_data_w-1:0] s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,

    input  logic                  frame_done,
    output logic                  out_enable,
    output pattern_e              pattern,
    output logic [2:0]            solid_color
);

    logic                  wr_en;
    logic                  wr_ok;
    logic                  rd_en;
    logic                  rd_ok;
    logic [axi_data_w-1:0] rd_data;

    logic                  pend_enable;
    pattern_e              pend_pattern;
    logic [2:0]            pend_color;
    logic                  cfg_pending;
    logic [31:0]           frame_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign wr_en = s_awready && s_awvalid && s_wvalid;
    assign wr_ok = (s_awaddr == reg_ctrl) || (s_awaddr == reg_color);

    always_ff @(posedge clk_50M, posedge rst) begin
        if (rst) begin
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            s_bvalid  <= 1'b0;
        end else begin
            // Address and data taken together, one at a time
            s_awready <= s_awvalid && s_wvalid && !s_awready && !s_bvalid;
            s_wready  <= s_awvalid && s_wvalid && !s_awready && !s_bvalid;
            if (wr_en) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_50M) begin
        if (wr_en) begin
            s_bresp <= wr_ok ? resp_okay : resp_slverr;
        end
    end

    always_ff @(posedge clk_50M, posedge rst) begin
        if (rst) begin
            pend_enable  <= 1'b0;
            pend_pattern <= pat_stripes;
            pend_color   <= 3'd0;
        end else if (wr_en) begin
            case (s_awaddr)
                reg_ctrl: begin
                    pend_enable  <= s_wdata[0];
                    pend_pattern <= pattern_e'(s_wdata[2:1]);
                end
                reg_color: begin
                    pend_color <= s_wdata[2:0];
                end
                default: ;                      // Read only or unmapped
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame boundary: active set and frame count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_50M, posedge rst) begin
        if (rst) begin
            out_enable  <= 1'b0;
            pattern     <= pat_stripes;
            solid_color <= 3'd0;
            frame_cnt   <= 32'd0;
        end else if (frame_done) begin
            out_enable  <= pend_enable;
            pattern     <= pend_pattern;
            solid_color <= pend_color;
            frame_cnt   <= frame_cnt + 32'd1;
        end
    end

    assign cfg_pending = (pend_enable != out_enable)
                      || (pend_pattern != pattern)
                      || (pend_color != solid_color);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rd_en = s_arready && s_arvalid;

    always_comb begin
        rd_ok   = 1'b1;
        rd_data = '0;
        case (s_araddr)
            reg_ctrl:   rd_data = {29'd0, pend_pattern, pend_enable};  // Pending copy
            reg_color:  rd_data = {29'd0, pend_color};
            reg_frames: rd_data = frame_cnt;
            reg_status: rd_data = {31'd0, cfg_pending};
            default:    rd_ok   = 1'b0;
        endcase
    end

    always_ff @(posedge clk_50M, posedge rst) begin
        if (rst) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
        end else begin
            s_arready <= s_arvalid && !s_arready && !s_rvalid;
            if (rd_en) begin
                s_rvalid <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_50M) begin
        if (rd_en) begin
            s_rdata <= rd_data;
            s_rresp <= rd_ok ? resp_okay : resp_slverr;
        end
    end

endmodule

//--- pattern_gen.sv
`timescale 1ns/1ps

module pattern_gen import vga_pkg::*; (
    input  logic             clk_50M,
    input  logic             rst,
    input  logic             pix_en,
    input  logic             hs_raw,
    input  logic             vs_raw,
    input  logic             visible,
    input  logic [cnt_w-1:0] row,
    input  logic [cnt_w-1:0] col,
    input  logic             out_enable,
    input  pattern_e         pattern,
    input  logic [2:0]       solid_color,
    output logic             hs,
    output logic             vs,
    output logic             blank,
    output logic [2:0]       rgb
);

    logic [2:0] stripe_color;
    logic       checker_on;
    logic [2:0] pattern_color;
    logic [2:0] color_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Colour select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stripe index doubles as the RGB code, black on the left to white on the right
    assign stripe_color = 3'(col / cnt_w'(stripe_width));
    assign checker_on   = row[checker_shift] ^ col[checker_shift];

    always_comb begin
        case (pattern)
            pat_solid:   pattern_color = solid_color;
            pat_checker: pattern_color = checker_on ? solid_color : 3'd0;
            default:     pattern_color = stripe_color;  // Reserved code too
        endcase
    end

    assign color_next = (visible && out_enable) ? pattern_color : 3'd0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_50M, posedge rst) begin
        if (rst) begin
            hs    <= 1'b1;                      // Syncs idle high
            vs    <= 1'b1;
            blank <= 1'b1;
            rgb   <= 3'd0;
        end else if (pix_en) begin
            hs    <= hs_raw;
            vs    <= vs_raw;
            blank <= ~visible;
            rgb   <= color_next;
        end
    end

endmodule

//--- vga_top.sv
`timescale 1ns/1ps

module vga_top import vga_pkg::*; (
    input  logic                  clk_50M,
    input  logic                  rst,

    input  logic [axi_addr_w-1:0] s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  logic [axi_data_w-1:0] s_wdata,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [1:0]            s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  logic [axi_addr_w-1:0] s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [axi_data_w-1:0] s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,

    output logic                  hs,
    output logic                  vs,
    output logic                  blank,
    output logic [2:0]            rgb,
    output logic                  pix_clk
);

    logic             pix_en;
    logic             hs_raw;
    logic             vs_raw;
    logic             visible;
    logic [cnt_w-1:0] row;
    logic [cnt_w-1:0] col;
    logic             frame_done;
    logic             out_enable;
    pattern_e         pattern;
    logic [2:0]       solid_color;

    vga_timing u_timing (
        .clk_50M    (clk_50M),
        .rst        (rst),
        .pix_en     (pix_en),
        .pix_clk    (pix_clk),
        .hs_raw     (hs_raw),
        .vs_raw     (vs_raw),
        .visible    (visible),
        .row        (row),
        .col        (col),
        .frame_done (frame_done)
    );

    vga_regs u_regs (
        .clk_50M     (clk_50M),
        .rst         (rst),
        .s_awaddr    (s_awaddr),
        .s_awvalid   (s_awvalid),
        .s_awready   (s_awready),
        .s_wdata     (s_wdata),
        .s_wvalid    (s_wvalid),
        .s_wready    (s_wready),
        .s_bresp     (s_bresp),
        .s_bvalid    (s_bvalid),
        .s_bready    (s_bready),
        .s_araddr    (s_araddr),
        .s_arvalid   (s_arvalid),
        .s_arready   (s_arready),
        .s_rdata     (s_rdata),
        .s_rresp     (s_rresp),
        .s_rvalid    (s_rvalid),
        .s_rready    (s_rready),
        .frame_done  (frame_done),
        .out_enable  (out_enable),
        .pattern     (pattern),
        .solid_color (solid_color)
    );

    pattern_gen u_pattern (
        .clk_50M     (clk_50M),
        .rst         (rst),
        .pix_en      (pix_en),
        .hs_raw      (hs_raw),
        .vs_raw      (vs_raw),
        .visible     (visible),
        .row         (row),
        .col         (col),
        .out_enable  (out_enable),
        .pattern     (pattern),
        .solid_color (solid_color),
        .hs          (hs),
        .vs          (vs),
        .blank       (blank),
        .rgb         (rgb)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_50M,
    output logic rst
);

    localparam int half_period_ns = 10;     // 20 ns period
    localparam int reset_cycles   = 10;

    initial begin
        clk_50M = 1'b0;
        forever begin
            #(half_period_ns) clk_50M = ~clk_50M;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk_50M);
        rst <= 1'b0;                        // Released on a rising edge
    end

endmodule

//--- tb_vga_top.sv
`timescale 1ns/1ps

module tb_vga_top import vga_pkg::*; ();

    localparam int     n_rounds     = 4;    // Mid-frame configuration changes
    localparam int     clk_ns       = 20;
    localparam int     axi_limit    = 50;   // Cycles allowed for a handshake
    localparam int     check_line   = 200;  // Line where configuration is written
    localparam int     print_limit  = 20;
    localparam longint watchdog_ns  = longint'(n_rounds + 3) * h_total * v_total * 2 * clk_ns
                                    + 100_000;

    logic                  clk_50M;
    logic                  rst;
    logic [axi_addr_w-1:0] s_awaddr;
    logic                  s_awvalid;
    logic                  s_awready;
    logic [axi_data_w-1:0] s_wdata;
    logic                  s_wvalid;
    logic                  s_wready;
    logic [1:0]            s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    logic [axi_addr_w-1:0] s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    logic [axi_data_w-1:0] s_rdata;
    logic [1:0]            s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;
    logic                  hs;
    logic                  vs;
    logic                  blank;
    logic [2:0]            rgb;
    logic                  pix_clk;

    integer seed;
    int     axi_errs = 0;
    int     video_errs = 0;
    int     other_errs = 0;

    // Register model, pending and active sets
    logic       pend_enable = 1'b0;
    logic [1:0] pend_pattern = 2'd0;
    logic [2:0] pend_color = 3'd0;
    logic       next_enable = 1'b0;
    logic [1:0] next_pattern = 2'd0;
    logic [2:0] next_color = 3'd0;
    logic       act_enable = 1'b0;
    logic [1:0] act_pattern = 2'd0;
    logic [2:0] act_color = 3'd0;

    // Video position model
    logic started = 1'b0;
    logic prev_vs = 1'b1;
    int   cur_h = 0;
    int   cur_v = 0;
    int   vs_falls = 0;
    int   frames_checked = 0;
    int   hs_low = 0;
    int   vs_low = 0;
    int   blank_low = 0;
    int   pix_cycles = 0;

    tb_clock_gen u_clock_gen (
        .clk_50M (clk_50M),
        .rst     (rst)
    );

    vga_top u_vga_top (
        .clk_50M   (clk_50M),
        .rst       (rst),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .hs        (hs),
        .vs        (vs),
        .blank     (blank),
        .rgb       (rgb),
        .pix_clk   (pix_clk)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic expect_axi(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            axi_errs++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_video(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            video_errs++;
            if (video_errs <= print_limit) begin
                $display("ERR %s at h=%0d v=%0d got %h expected %h",
                         name, cur_h, cur_v, got, exp);
            end
        end
    endtask

    task automatic expect_count(input string what, input int got, input int exp);
        assert (got == exp) else begin
            other_errs++;
            $display("%s was seen %0d times in a frame instead of %0d", what, got, exp);
        end
    endtask

    function automatic logic [31:0] frames_expected();
        return (vs_falls > 0) ? 32'(vs_falls - 1) : 32'd0;
    endfunction

    function automatic logic config_pending();
        return (pend_enable != act_enable) || (pend_pattern != act_pattern)
            || (pend_color != act_color);
    endfunction

    task automatic report_counts();
        $display("Errors: axi %0d, video %0d, other %0d, frames checked %0d",
                 axi_errs, video_errs, other_errs, frames_checked);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite master tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        int delay;
        @(posedge clk_50M);
        s_awaddr  <= addr;
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wvalid  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk_50M);
            n++;
        end while (!s_awready && n < axi_limit);
        assert (s_awready && s_wready) else begin
            other_errs++;
            $display("Write to address %h was not accepted in time", addr);
        end
        @(posedge clk_50M);                     // Handshake completes here
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        n = 0;
        while (!s_bvalid && n < axi_limit) begin
            @(negedge clk_50M);
            n++;
        end
        assert (s_bvalid) else begin
            other_errs++;
            $display("Write to address %h got no response", addr);
        end
        resp  = s_bresp;
        delay = $unsigned($random(seed)) % 4;   // Back-pressure
        repeat (delay) @(posedge clk_50M);
        @(posedge clk_50M);
        s_bready <= 1'b1;
        @(posedge clk_50M);
        s_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        int delay;
        @(posedge clk_50M);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk_50M);
            n++;
        end while (!s_arready && n < axi_limit);
        assert (s_arready) else begin
            other_errs++;
            $display("Read of address %h was not accepted in time", addr);
        end
        @(posedge clk_50M);
        s_arvalid <= 1'b0;
        n = 0;
        while (!s_rvalid && n < axi_limit) begin
            @(negedge clk_50M);
            n++;
        end
        assert (s_rvalid) else begin
            other_errs++;
            $display("Read of address %h got no response", addr);
        end
        data  = s_rdata;
        resp  = s_rresp;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk_50M);
        @(posedge clk_50M);
        s_rready <= 1'b1;
        @(posedge clk_50M);
        s_rready <= 0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        if (addr == reg_ctrl) begin
            expect_axi("s_bresp", resp, resp_okay);
            pend_enable  = data[0];
            pend_pattern = data[2:1];
        end else if (addr == reg_color) begin
            expect_axi("s_bresp", resp, resp_okay);
            pend_color = data[2:0];
        end else begin
            expect_axi("s_bresp", resp, resp_slverr);     // Nothing may change
        end
    endtask

    task automatic read_reg(input logic [3:0] addr);
        logic [31:0] data;
        logic [1:0]  resp;
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        axi_read(addr, data, resp);
        exp_resp = resp_okay;
        case (addr)
            reg_ctrl:   exp_data = {29'd0, pend_pattern, pend_enable};
            reg_color:  exp_data = {29'd0, pend_color};
            reg_frames: exp_data = frames_expected();
            reg_status: exp_data = {31'd0, config_pending()};
            default: begin
                exp_resp = resp_slverr;
            end
        endcase
        expect_axi("s_rresp", resp, exp_resp);
        if (exp_resp == resp_okay) begin        // Data undefined on error
            expect_axi("s_rdata", data, exp_data);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Video reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_pixel();
        int         col;
        int         row;
        logic       vis;
        logic [2:0] exp_rgb;
        vis = (cur_h >= h_offset) && (cur_h < h_offset + h_visible)
           && (cur_v >= v_offset) && (cur_v < v_offset + v_visible);
        col = cur_h - h_offset;
        row = cur_v - v_offset;
        exp_rgb = 3'd0;
        if (vis && act_enable) begin
            case (act_pattern)
                pat_solid:   exp_rgb = act_color;
                pat_checker: exp_rgb = ((row / 32 + col / 32) % 2 == 1) ? act_color : 3'd0;
                default:     exp_rgb = 3'(col / stripe_width);
            endcase
        end
        expect_video("hs", hs, cur_h > h_sync_end);
        expect_video("vs", vs, cur_v > v_sync_end);
        expect_video("blank", blank, !vis);
        expect_video("rgb", rgb, exp_rgb);
        if (!hs) hs_low++;
        if (!vs) vs_low++;
        if (!blank) blank_low++;
        if (cur_h == h_total - 1 && cur_v == v_total - 1) begin
            expect_count("HS low", hs_low, (h_sync_end + 1) * v_total);
            expect_count("VS low", vs_low, (v_sync_end + 1) * h_total);
            expect_count("Blank low", blank_low, h_visible * v_visible);
            hs_low       = 0;
            vs_low       = 0;
            blank_low    = 0;
            frames_checked++;
            next_enable  = pend_enable;         // Taken at the frame boundary
            next_pattern = pend_pattern;
            next_color   = pend_color;
        end
    endtask

    // Outputs change on the edge where pix_clk rises, one sample per pixel
    always @(negedge clk_50M) begin
        if (!rst) begin
            expect_video("pix_clk", pix_clk, pix_cycles % 2);  // Low first, then toggles
            pix_cycles++;
        end
        if (!rst && pix_clk) begin
            if (!vs && prev_vs) begin
                if (started) begin
                    assert (cur_h == h_total - 1 && cur_v == v_total - 1) else begin
                        other_errs++;
                        $display("VS fell at h=%0d v=%0d, not at the end of a frame",
                                 cur_h, cur_v);
                    end
                end
                started     = 1'b1;
                cur_h       = 0;
                cur_v       = 0;
                vs_falls++;
                act_enable  = next_enable;
                act_pattern = next_pattern;
                act_color   = next_color;
            end else if (started) begin
                if (cur_h == h_total - 1) begin
                    cur_h = 0;
                    cur_v = (cur_v == v_total - 1) ? 0 : cur_v + 1;
                end else begin
                    cur_h++;
                end
            end
            prev_vs = vs;
            if (started) begin
                check_pixel();
            end
        end
    end

    task automatic wait_frame_line(input int line);
        int f0;
        f0 = vs_falls;
        while (!(vs_falls > f0 && cur_v == line)) begin
            @(posedge clk_50M);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int         i;
        int         f0;
        logic [3:0] addr;
        seed      = 32'h0844_22a9;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;

        repeat (5) @(negedge clk_50M);          // Still in reset
        expect_axi("s_awready", s_awready, 0);
        expect_axi("s_wready", s_wready, 0);
        expect_axi("s_bvalid", s_bvalid, 0);
        expect_axi("s_arready", s_arready, 0);
        expect_axi("s_rvalid", s_rvalid, 0);
        expect_video("hs", hs, 1);
        expect_video("vs", vs, 1);
        expect_video("blank", blank, 1);
        expect_video("rgb", rgb, 0);
        expect_video("pix_clk", pix_clk, 0);
        wait (rst == 1'b0);
        repeat (4) @(posedge clk_50M);
        read_reg(reg_ctrl);
        read_reg(reg_color);
        read_reg(reg_frames);
        read_reg(reg_status);

        for (i = 0; i < 40; i++) begin
            addr = $random(seed);
            if ($random(seed) & 1) begin
                write_reg(addr, $random(seed));
            end else begin
                read_reg(addr);
            end
        end
        write_reg(reg_frames, 32'hffff_ffff);
        write_reg(reg_status, 32'hffff_ffff);
        read_reg(reg_frames);
        read_reg(reg_status);

        wait_frame_line(check_line);
        for (i = 0; i < n_rounds; i++) begin
            write_reg(reg_ctrl, $random(seed));
            write_reg(reg_color, $random(seed));
            read_reg(reg_ctrl);
            read_reg(reg_color);
            read_reg(reg_status);
            read_reg(reg_frames);
            wait_frame_line(check_line);
            read_reg(reg_status);
            read_reg(reg_frames);
        end
        f0 = vs_falls;
        while (vs_falls == f0) begin
            @(posedge clk_50M);                 // Let the last frame finish
        end
        repeat (10) @(posedge clk_50M);
        expect_count("A fully checked frame", frames_checked, n_rounds + 2);

        report_counts();
        if (axi_errs + video_errs + other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns with the tests still running", watchdog_ns);
        report_counts();
        $display("Test failed");
        $finish;
    end

endmodule

//--- project.f
vga_pkg.sv
vga_timing.sv
vga_regs.sv
pattern_gen.sv
vga_top.sv
tb_clock_gen.sv
tb_vga_top.sv
